//--- Makefile
SIM      := verilator
TOP      := tb_mmu
FILELIST := tb.f
BUILD    := obj_dir
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD)

BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(BUILD)

//--- common/priv_exc_pkg.sv
`default_nettype none

package priv_exc_pkg;

    // effective privilege of the load/store access
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_t;

    // mcause codes raised by the translator
    typedef enum logic [3:0] {
        LOAD_PAGE_FAULT  = 4'd13,
        STORE_PAGE_FAULT = 4'd15
    } exc_cause_t;

    // tval carries the faulting virtual address
    typedef struct packed {
        exc_cause_t  cause;
        logic [31:0] tval;
        logic        valid;
    } exception_t;

endpackage

`default_nettype wire

//--- common/sv32_page_pkg.sv
`default_nettype none

package sv32_page_pkg;

    // --------------------
    // address widths
    // --------------------
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPNW          = 22;
    localparam int unsigned PAGE_OFFSET_W = 12;

    // depth of the fully associative data tlb, a power of two
    localparam int unsigned DTLB_ENTRIES  = 4;

    // one pte is a 32-bit word
    localparam int unsigned PTE_BYTES     = 4;

    // --------------------
    // page table entry
    // --------------------
    // sv32 layout, msb first
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // tlb fill from the walker
    // vpn is vaddr[31:12], is_4m marks a level-1 leaf
    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
        logic        is_4m;
        pte_t        pte;
    } tlb_update_t;

    // --------------------
    // pte memory port
    // --------------------
    // addr is the byte address of a word aligned pte
    typedef struct packed {
        logic            req;
        logic [PLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/data_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module data_xlate (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           en_ld_st_translation_i,
    input  logic                           lsu_req_i,
    input  logic [sv32_page_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                           lsu_is_store_i,
    input  logic                           sum_i,
    input  priv_exc_pkg::priv_lvl_t        ld_st_priv_lvl_i,
    input  logic                           dtlb_hit_i,
    input  sv32_page_pkg::pte_t            dtlb_pte_i,
    input  logic                           dtlb_is_4m_i,
    input  logic                           ptw_busy_i,
    input  logic                           walk_error_i,
    output logic                           lsu_dtlb_hit_o,
    output logic                           lsu_valid_o,
    output logic [sv32_page_pkg::PLEN-1:0] lsu_paddr_o,
    output priv_exc_pkg::exception_t       lsu_exception_o,
    output logic                           walk_start_o,
    output logic                           dtlb_miss_o
);

    logic                           req_q;
    logic                           hit_q;
    logic                           is_store_q;
    logic                           is_4m_q;
    logic [sv32_page_pkg::VLEN-1:0] vaddr_q;
    sv32_page_pkg::pte_t            pte_q;
    logic                           access_err;
    logic                           perm_fault;

    // --------------------
    // request stage
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= dtlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        pte_q      <= dtlb_pte_i;
        is_4m_q    <= dtlb_is_4m_i;
    end

    // bare mode is always ready
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;

    // s mode reaches user pages only with sum, u mode only user pages
    assign access_err = ((ld_st_priv_lvl_i == priv_exc_pkg::PRIV_S) && !sum_i && pte_q.u)
                     || ((ld_st_priv_lvl_i == priv_exc_pkg::PRIV_U) && !pte_q.u);

    // stores need w and d, loads need r
    assign perm_fault = access_err || (is_store_q ? (!pte_q.w || !pte_q.d) : !pte_q.r);

    // walk only if the held request still misses now
    assign walk_start_o = en_ld_st_translation_i && req_q && !hit_q && !ptw_busy_i
                       && lsu_req_i && !dtlb_hit_i;
    // perf counter, one pulse per walk
    assign dtlb_miss_o  = walk_start_o;

    // --------------------
    // response
    // --------------------
    always_comb begin
        lsu_paddr_o           = {{(sv32_page_pkg::PLEN - sv32_page_pkg::VLEN){1'b0}}, vaddr_q};
        lsu_valid_o           = req_q;
        lsu_exception_o.cause = is_store_q ? priv_exc_pkg::STORE_PAGE_FAULT
                                           : priv_exc_pkg::LOAD_PAGE_FAULT;
        lsu_exception_o.tval  = vaddr_q;
        lsu_exception_o.valid = 1'b0;

        if (en_ld_st_translation_i) begin
            lsu_valid_o = 1'b0;
            lsu_paddr_o = {pte_q.ppn1, pte_q.ppn0, vaddr_q[11:0]};
            // megapage keeps vpn0 as part of the offset
            if (is_4m_q) begin
                lsu_paddr_o[21:12] = vaddr_q[21:12];
            end
            if (req_q && hit_q) begin
                lsu_valid_o           = 1'b1;
                lsu_exception_o.valid = perm_fault;
            end else if (req_q && walk_error_i) begin
                // a failed walk ends the request with a page fault
                lsu_valid_o           = 1'b1;
                lsu_exception_o.valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dtlb.sv
`timescale 1ns/1ps
`default_nettype none

module dtlb (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           flush_i,
    input  sv32_page_pkg::tlb_update_t     update_i,
    input  logic [sv32_page_pkg::VLEN-1:0] lu_vaddr_i,
    output logic                           lu_hit_o,
    output sv32_page_pkg::pte_t            lu_pte_o,
    output logic                           lu_is_4m_o
);

    // tag of one entry
    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        logic       is_4m;
    } tag_t;

    tag_t                                           tags_q [sv32_page_pkg::DTLB_ENTRIES];
    sv32_page_pkg::pte_t                            ptes_q [sv32_page_pkg::DTLB_ENTRIES];
    logic [sv32_page_pkg::DTLB_ENTRIES-1:0]         valid_q;
    logic [sv32_page_pkg::DTLB_ENTRIES-1:0]         match;
    // next entry to be filled
    logic [$clog2(sv32_page_pkg::DTLB_ENTRIES)-1:0] victim_q;

    // --------------------
    // lookup
    // --------------------
    always_comb begin
        for (int i = 0; i < sv32_page_pkg::DTLB_ENTRIES; i++) begin
            // a megapage entry only compares vpn1
            match[i] = valid_q[i]
                    && (tags_q[i].vpn1 == lu_vaddr_i[31:22])
                    && (tags_q[i].is_4m || (tags_q[i].vpn0 == lu_vaddr_i[21:12]));
        end
    end

    // pick the first matching entry
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_pte_o   = ptes_q[0];
        lu_is_4m_o = 1'b0;
        for (int i = 0; i < sv32_page_pkg::DTLB_ENTRIES; i++) begin
            if (match[i] && !lu_hit_o) begin
                lu_hit_o   = 1'b1;
                lu_pte_o   = ptes_q[i];
                lu_is_4m_o = tags_q[i].is_4m;
            end
        end
    end

    // --------------------
    // fill and flush
    // --------------------
    // flush wins over a fill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[victim_q] <= 1'b1;
            // round robin, wraps at the depth
            victim_q <= victim_q + 1'b1;
        end
    end

    // tag and pte of the victim entry
    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tags_q[victim_q].vpn1  <= update_i.vpn[19:10];
            tags_q[victim_q].vpn0  <= update_i.vpn[9:0];
            tags_q[victim_q].is_4m <= update_i.is_4m;
            ptes_q[victim_q]       <= update_i.pte;
        end
    end

endmodule

`default_nettype wire

//--- design/mmu_sv32_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_sv32_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           en_ld_st_translation_i,
    input  logic                           flush_tlb_i,
    input  logic                           lsu_req_i,
    input  logic [sv32_page_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                           lsu_is_store_i,
    input  logic                           sum_i,
    input  priv_exc_pkg::priv_lvl_t        ld_st_priv_lvl_i,
    input  logic [sv32_page_pkg::PPNW-1:0] satp_ppn_i,
    input  sv32_page_pkg::mem_rsp_t        mem_rsp_i,
    output logic                           lsu_dtlb_hit_o,
    output logic                           lsu_valid_o,
    output logic [sv32_page_pkg::PLEN-1:0] lsu_paddr_o,
    output priv_exc_pkg::exception_t       lsu_exception_o,
    output logic                           dtlb_miss_o,
    output sv32_page_pkg::mem_req_t        mem_req_o
);

    // --------------------
    // internal wires
    // --------------------
    logic                       dtlb_hit;
    sv32_page_pkg::pte_t        dtlb_pte;
    logic                       dtlb_is_4m;
    sv32_page_pkg::tlb_update_t tlb_update;
    logic                       walk_start;
    logic                       ptw_busy;
    logic                       walk_error;

    // lookup uses the live request address
    dtlb i_dtlb (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_tlb_i),
        .update_i   (tlb_update),
        .lu_vaddr_i (lsu_vaddr_i),
        .lu_hit_o   (dtlb_hit),
        .lu_pte_o   (dtlb_pte),
        .lu_is_4m_o (dtlb_is_4m)
    );

    // the walk takes the held request straight from the LSU
    ptw_sv32 i_ptw (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .walk_start_i    (walk_start),
        .walk_vaddr_i    (lsu_vaddr_i),
        .walk_is_store_i (lsu_is_store_i),
        .satp_ppn_i      (satp_ppn_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_req_o       (mem_req_o),
        .ptw_busy_o      (ptw_busy),
        .walk_error_o    (walk_error),
        .tlb_update_o    (tlb_update)
    );

    data_xlate i_data_xlate (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lsu_req_i              (lsu_req_i),
        .lsu_vaddr_i            (lsu_vaddr_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .sum_i                  (sum_i),
        .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
        .dtlb_hit_i             (dtlb_hit),
        .dtlb_pte_i             (dtlb_pte),
        .dtlb_is_4m_i           (dtlb_is_4m),
        .ptw_busy_i             (ptw_busy),
        .walk_error_i           (walk_error),
        .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
        .lsu_valid_o            (lsu_valid_o),
        .lsu_paddr_o            (lsu_paddr_o),
        .lsu_exception_o        (lsu_exception_o),
        .walk_start_o           (walk_start),
        .dtlb_miss_o            (dtlb_miss_o)
    );

endmodule

`default_nettype wire

//--- ptw/ptw_sv32.sv
`timescale 1ns/1ps
`default_nettype none

module ptw_sv32 (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           walk_start_i,
    input  logic [sv32_page_pkg::VLEN-1:0] walk_vaddr_i,
    input  logic                           walk_is_store_i,
    input  logic [sv32_page_pkg::PPNW-1:0] satp_ppn_i,
    input  sv32_page_pkg::mem_rsp_t        mem_rsp_i,
    output sv32_page_pkg::mem_req_t        mem_req_o,
    output logic                           ptw_busy_o,
    output logic                           walk_error_o,
    output sv32_page_pkg::tlb_update_t     tlb_update_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } state_e;

    state_e                         state_q, state_d;
    // high while the level-1 pte is read
    logic                           level_q, level_d;
    logic [sv32_page_pkg::VLEN-1:0] vaddr_q, vaddr_d;
    logic                           is_store_q, is_store_d;
    logic [sv32_page_pkg::PLEN-1:0] addr_q, addr_d;
    sv32_page_pkg::tlb_update_t     update_q, update_d;

    sv32_page_pkg::pte_t            pte;
    logic [sv32_page_pkg::PLEN-1:0] l1_addr;
    logic [sv32_page_pkg::PLEN-1:0] l0_addr;
    logic                           is_leaf;
    logic                           pte_fault;

    assign pte = sv32_page_pkg::pte_t'(mem_rsp_i.rdata);

    // --------------------
    // pte addresses
    // --------------------
    // root table from satp, indexed by vpn1
    assign l1_addr = {satp_ppn_i, {sv32_page_pkg::PAGE_OFFSET_W{1'b0}}}
                   + walk_vaddr_i[31:22] * sv32_page_pkg::PTE_BYTES;
    // second table from the pointer pte, indexed by vpn0
    assign l0_addr = {pte.ppn1, pte.ppn0, {sv32_page_pkg::PAGE_OFFSET_W{1'b0}}}
                   + vaddr_q[21:12] * sv32_page_pkg::PTE_BYTES;

    // --------------------
    // pte checks
    // --------------------
    // r or x set means leaf, otherwise pointer
    assign is_leaf = pte.r || pte.x;

    // invalid or reserved w-only encoding
    // pointer at the last level
    // misaligned megapage
    // accessed clear, or dirty clear on a store
    assign pte_fault = !pte.v
                    || (pte.w && !pte.r)
                    || (!is_leaf && !level_q)
                    || (is_leaf && level_q && (pte.ppn0 != '0))
                    || (is_leaf && !pte.a)
                    || (is_leaf && is_store_q && !pte.d);

    // --------------------
    // walk FSM
    // --------------------
    always_comb begin
        state_d        = state_q;
        level_d        = level_q;
        vaddr_d        = vaddr_q;
        is_store_d     = is_store_q;
        addr_d         = addr_q;
        update_d       = update_q;
        update_d.valid = 1'b0;

        case (state_q)
            IDLE: begin
                if (walk_start_i) begin
                    state_d    = WAIT_GRANT;
                    level_d    = 1'b1;
                    vaddr_d    = walk_vaddr_i;
                    is_store_d = walk_is_store_i;
                    addr_d     = l1_addr;
                end
            end
            // req stays up with a fixed address until granted
            WAIT_GRANT: begin
                if (mem_rsp_i.gnt) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (mem_rsp_i.rvalid) begin
                    if (pte_fault) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (!is_leaf) begin
                        // descend to level 0
                        state_d = WAIT_GRANT;
                        level_d = 1'b0;
                        addr_d  = l0_addr;
                    end else begin
                        state_d        = IDLE;
                        update_d.valid = 1'b1;
                        update_d.vpn   = vaddr_q[31:12];
                        update_d.is_4m = level_q;
                        update_d.pte   = pte;
                    end
                end
            end
            PROPAGATE_ERROR: state_d = IDLE;
            default:         state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            level_q  <= 1'b0;
            update_q <= '0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            update_q <= update_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= vaddr_d;
        is_store_q <= is_store_d;
        addr_q     <= addr_d;
    end

    assign mem_req_o.req  = (state_q == WAIT_GRANT);
    assign mem_req_o.addr = addr_q;

    // busy also covers the fill cycle, the tlb is written at its end
    assign ptw_busy_o   = (state_q != IDLE) || update_q.valid;
    assign walk_error_o = (state_q == PROPAGATE_ERROR);
    assign tlb_update_o = update_q;

endmodule

`default_nettype wire

//--- tb.f
common/sv32_page_pkg.sv
common/priv_exc_pkg.sv
design/dtlb.sv
ptw/ptw_sv32.sv
design/data_xlate.sv
design/mmu_sv32_top.sv
tb/tb_page_mem.sv
tb/tb_mmu.sv

//--- tb/tb_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu;

    localparam int unsigned PLEN           = sv32_page_pkg::PLEN;
    localparam int unsigned TIMEOUT_CYCLES = 50;
    // root page table lives at ppn 1 of the page memory
    localparam logic [21:0] ROOT_PPN       = 22'd1;
    // pte flag bits
    localparam logic [7:0]  PTE_V          = 8'h01;
    localparam logic [7:0]  PTE_R          = 8'h02;
    localparam logic [7:0]  PTE_W          = 8'h04;
    localparam logic [7:0]  PTE_U          = 8'h10;
    localparam logic [7:0]  PTE_A          = 8'h40;
    localparam logic [7:0]  PTE_D          = 8'h80;
    localparam logic [7:0]  PTE_RWAD       = PTE_V | PTE_R | PTE_W | PTE_A | PTE_D;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      en_ld_st_translation_i;
    logic                      flush_tlb_i;
    logic                      lsu_req_i;
    logic [31:0]               lsu_vaddr_i;
    logic                      lsu_is_store_i;
    logic                      sum_i;
    priv_exc_pkg::priv_lvl_t   ld_st_priv_lvl_i;
    logic [21:0]               satp_ppn_i;
    sv32_page_pkg::mem_rsp_t   mem_rsp;
    sv32_page_pkg::mem_req_t   mem_req;
    logic                      lsu_dtlb_hit_o;
    logic                      lsu_valid_o;
    logic [PLEN-1:0]           lsu_paddr_o;
    priv_exc_pkg::exception_t  lsu_exception_o;
    logic                      dtlb_miss_o;

    int          mismatch_count;
    int          failure_count;
    logic [31:0] seed;
    string       cur_test;

    mmu_sv32_top i_mmu_sv32_top (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .flush_tlb_i            (flush_tlb_i),
        .lsu_req_i              (lsu_req_i),
        .lsu_vaddr_i            (lsu_vaddr_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .sum_i                  (sum_i),
        .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
        .satp_ppn_i             (satp_ppn_i),
        .mem_rsp_i              (mem_rsp),
        .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
        .lsu_valid_o            (lsu_valid_o),
        .lsu_paddr_o            (lsu_paddr_o),
        .lsu_exception_o        (lsu_exception_o),
        .dtlb_miss_o            (dtlb_miss_o),
        .mem_req_o              (mem_req)
    );

    tb_page_mem i_page_mem (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    always #20 clk_i = ~clk_i;

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        seed = xorshift32(seed);
        r    = seed;
    endtask

    // sv32 pte with rsw zero
    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // level-1 entry of the root table, indexed by vpn1
    task automatic write_l1(input logic [31:0] vaddr, input logic [31:0] pte);
        i_page_mem.mem_q[int'(ROOT_PPN) * 1024 + int'(vaddr[31:22])] = pte;
    endtask

    // level-0 entry of the table at table_ppn, indexed by vpn0
    task automatic write_l0(input int table_ppn, input logic [31:0] vaddr,
                            input logic [31:0] pte);
        i_page_mem.mem_q[table_ppn * 1024 + int'(vaddr[21:12])] = pte;
    endtask

    task automatic set_mode(input logic en, input priv_exc_pkg::priv_lvl_t priv,
                            input logic sum);
        @(posedge clk_i);
        en_ld_st_translation_i <= en;
        ld_st_priv_lvl_i       <= priv;
        sum_i                  <= sum;
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        flush_tlb_i <= 1'b1;
        @(posedge clk_i);
        flush_tlb_i <= 1'b0;
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic compare_paddr(input string name, input logic [PLEN-1:0] got,
                                 input logic [PLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got=%h exp=%h in %s", name, got, exp, cur_test);
        end
    endtask

    // cause and tval only matter when a fault is expected
    task automatic compare_exception(input string name, input priv_exc_pkg::exception_t got,
                                     input priv_exc_pkg::exception_t exp);
        logic bad;
        bad = (got.valid !== exp.valid)
           || (exp.valid && ((got.cause !== exp.cause) || (got.tval !== exp.tval)));
        if (bad) begin
            mismatch_count++;
            $display("MISMATCH %s got=%h exp=%h in %s", name, got, exp, cur_test);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got=%h exp=%h in %s", name, got, exp, cur_test);
        end
    endtask

    // --------------------
    // one load/store access
    // --------------------
    // holds the request until a hit is seen or valid pulses, then drops it
    task automatic run_access(input logic [31:0] vaddr, input logic is_store,
                              input logic [PLEN-1:0] exp_paddr, input logic exp_fault,
                              input logic exp_first_hit, input logic exp_miss);
        int                       cycle;
        int                       hit_cycle;
        int                       misses;
        logic                     first_hit;
        logic                     done;
        logic [PLEN-1:0]          paddr;
        priv_exc_pkg::exception_t exc;
        priv_exc_pkg::exception_t exp_exc;

        exp_exc.valid = exp_fault;
        exp_exc.cause = is_store ? priv_exc_pkg::STORE_PAGE_FAULT
                                 : priv_exc_pkg::LOAD_PAGE_FAULT;
        exp_exc.tval  = vaddr;
        cycle     = 0;
        hit_cycle = -1;
        misses    = 0;
        first_hit = 1'b0;
        done      = 1'b0;
        paddr     = '0;
        exc       = '0;

        @(posedge clk_i);
        lsu_req_i      <= 1'b1;
        lsu_vaddr_i    <= vaddr;
        lsu_is_store_i <= is_store;

        while (!done && cycle < TIMEOUT_CYCLES) begin
            // sample in the middle of the cycle
            @(negedge clk_i);
            cycle++;
            if (cycle == 1) begin
                first_hit = lsu_dtlb_hit_o;
            end
            if (dtlb_miss_o) begin
                misses++;
            end
            // a hit seen in the valid cycle itself means valid came too early
            if (lsu_req_i && lsu_dtlb_hit_o && hit_cycle < 0) begin
                hit_cycle = cycle;
            end
            if (lsu_valid_o) begin
                done  = 1'b1;
                paddr = lsu_paddr_o;
                exc   = lsu_exception_o;
            end
            @(posedge clk_i);
            if (done || hit_cycle >= 0) begin
                lsu_req_i <= 1'b0;
            end
        end

        if (!done) begin
            failure_count++;
            lsu_req_i <= 1'b0;
            $display("timeout: no lsu_valid_o within %0d cycles in %s", TIMEOUT_CYCLES, cur_test);
        end else begin
            compare_flag("lsu_dtlb_hit_o", first_hit, exp_first_hit);
            compare_flag("dtlb_miss_o", misses != 0, exp_miss);
            if (misses > 1) begin
                failure_count++;
                $display("dtlb_miss_o pulsed %0d times for one access in %s", misses, cur_test);
            end
            // valid follows a hit after exactly one cycle
            if (hit_cycle >= 0) begin
                compare_flag("lsu_valid_o", (cycle - hit_cycle) == 1, 1'b1);
            end
            compare_exception("lsu_exception_o", exc, exp_exc);
            if (!exp_fault) begin
                compare_paddr("lsu_paddr_o", paddr, exp_paddr);
            end
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_bare_mode();
        logic [31:0] r;
        cur_test = "bare mode";
        set_mode(1'b0, priv_exc_pkg::PRIV_S, 1'b0);
        draw_random(r);
        run_access(r, 1'b0, {2'b00, r}, 1'b0, 1'b1, 1'b0);
        draw_random(r);
        run_access(r, 1'b1, {2'b00, r}, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic test_4k_page();
        logic [31:0] r;
        logic [31:0] va;
        cur_test = "4 KiB walk and hit";
        set_mode(1'b1, priv_exc_pkg::PRIV_S, 1'b0);
        draw_random(r);
        va = {10'h040, 10'h015, r[11:0]};
        write_l1(va, make_pte(22'd2, PTE_V));
        write_l0(2, va, make_pte(22'h12345, PTE_RWAD));
        run_access(va, 1'b0, {22'h12345, va[11:0]}, 1'b0, 1'b0, 1'b1);
        // same page, new offset, now a hit
        draw_random(r);
        va[11:0] = r[11:0];
        run_access(va, 1'b1, {22'h12345, va[11:0]}, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic test_megapage();
        logic [31:0] r;
        logic [31:0] va;
        cur_test = "megapage";
        draw_random(r);
        va = {10'h081, r[21:0]};
        write_l1(va, make_pte({12'h3a5, 10'h000}, PTE_RWAD));
        run_access(va, 1'b0, {12'h3a5, va[21:0]}, 1'b0, 1'b0, 1'b1);
        // anywhere within the same 4 MiB
        draw_random(r);
        va[21:0] = r[21:0];
        run_access(va, 1'b0, {12'h3a5, va[21:0]}, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic test_permissions();
        logic [31:0] r;
        logic [31:0] va_ro;
        logic [31:0] va_user;
        logic [31:0] va_sup;
        cur_test = "permissions";
        draw_random(r);
        va_ro   = {10'h0c0, 10'h020, r[11:0]};
        va_user = {10'h0c0, 10'h021, r[11:0]};
        va_sup  = {10'h0c0, 10'h022, r[11:0]};
        write_l1(va_ro, make_pte(22'd3, PTE_V));
        write_l0(3, va_ro, make_pte(22'h00777, PTE_V | PTE_R | PTE_A | PTE_D));
        write_l0(3, va_user, make_pte(22'h00888, PTE_RWAD | PTE_U));
        write_l0(3, va_sup, make_pte(22'h00999, PTE_RWAD));
        // store to a read-only page
        run_access(va_ro, 1'b1, '0, 1'b1, 1'b0, 1'b1);
        // s mode on a user page, sum off then on
        run_access(va_user, 1'b0, '0, 1'b1, 1'b0, 1'b1);
        set_mode(1'b1, priv_exc_pkg::PRIV_S, 1'b1);
        run_access(va_user, 1'b0, {22'h00888, va_user[11:0]}, 1'b0, 1'b1, 1'b0);
        // u mode on a supervisor page
        set_mode(1'b1, priv_exc_pkg::PRIV_U, 1'b0);
        run_access(va_sup, 1'b0, '0, 1'b1, 1'b0, 1'b1);
        set_mode(1'b1, priv_exc_pkg::PRIV_S, 1'b0);
    endtask

    task automatic test_walk_faults();
        logic [31:0] r;
        logic [31:0] va;
        cur_test = "walk faults";
        draw_random(r);
        // invalid level-1 pte
        va = {10'h100, r[21:0]};
        write_l1(va, 32'h0);
        run_access(va, 1'b0, '0, 1'b1, 1'b0, 1'b1);
        // megapage leaf with ppn0 nonzero
        va = {10'h101, r[21:0]};
        write_l1(va, make_pte({12'h055, 10'h001}, PTE_RWAD));
        run_access(va, 1'b1, '0, 1'b1, 1'b0, 1'b1);
        // leaf with accessed clear
        va = {10'h102, 10'h030, r[11:0]};
        write_l1(va, make_pte(22'd2, PTE_V));
        write_l0(2, va, make_pte(22'h00456, PTE_V | PTE_R | PTE_W | PTE_D));
        run_access(va, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic test_flush();
        logic [31:0] r;
        logic [31:0] va;
        cur_test = "flush";
        draw_random(r);
        va = {10'h140, 10'h040, r[11:0]};
        write_l1(va, make_pte(22'd2, PTE_V));
        write_l0(2, va, make_pte(22'h0abcd, PTE_RWAD));
        run_access(va, 1'b0, {22'h0abcd, va[11:0]}, 1'b0, 1'b0, 1'b1);
        run_access(va, 1'b0, {22'h0abcd, va[11:0]}, 1'b0, 1'b1, 1'b0);
        // remap the page, the stale entry must be gone after the flush
        write_l0(2, va, make_pte(22'h1f00f, PTE_RWAD));
        pulse_flush();
        run_access(va, 1'b0, {22'h1f00f, va[11:0]}, 1'b0, 1'b0, 1'b1);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk_i                  = 1'b0;
        rst_ni                 = 1'b0;
        en_ld_st_translation_i = 1'b0;
        flush_tlb_i            = 1'b0;
        lsu_req_i              = 1'b0;
        lsu_vaddr_i            = '0;
        lsu_is_store_i         = 1'b0;
        sum_i                  = 1'b0;
        ld_st_priv_lvl_i       = priv_exc_pkg::PRIV_S;
        satp_ppn_i             = ROOT_PPN;
        seed                   = 32'hef13;
        mismatch_count         = 0;
        failure_count          = 0;
        cur_test               = "reset";

        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        // outputs idle out of reset
        @(negedge clk_i);
        compare_flag("lsu_valid_o", lsu_valid_o, 1'b0);
        compare_flag("dtlb_miss_o", dtlb_miss_o, 1'b0);
        compare_flag("mem_req_o.req", mem_req.req, 1'b0);

        test_bare_mode();
        test_4k_page();
        test_megapage();
        test_permissions();
        test_walk_faults();
        test_flush();

        repeat (2) @(posedge clk_i);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_page_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_page_mem (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  sv32_page_pkg::mem_req_t mem_req_i,
    output sv32_page_pkg::mem_rsp_t mem_rsp_o
);

    // 16 KiB of page tables, four 4 KiB tables, ppn 0 to 3
    localparam int unsigned WORDS = 4096;

    // written by the testbench through hierarchical access
    logic [31:0] mem_q [WORDS];
    logic        rvalid_q;
    logic [31:0] rdata_q;

    // --------------------
    // init
    // --------------------
    // every pte starts out invalid
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // grant in the cycle the request shows up
    assign mem_rsp_o.gnt    = mem_req_i.req;
    assign mem_rsp_o.rvalid = rvalid_q;
    assign mem_rsp_o.rdata  = rdata_q;

    // --------------------
    // read response
    // --------------------
    // data comes one cycle after the grant, word index from byte address
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= mem_req_i.req;
            if (mem_req_i.req) begin
                rdata_q <= mem_q[mem_req_i.addr[13:2]];
            end
        end
    end

endmodule

`default_nettype wire
